// File: flist.f
logic/apbBridgePkg.sv
logic/apbReqIf.sv
logic/slotDecoder.sv
logic/indirectAddrReg.sv
logic/responseMux.sv
logic/apbSlotBridge.sv
verification/bridgeChecker.sv
verification/tbApbSlotBridge.sv

// File: Bender.yml
package:
  name: apb_slot_bridge

sources:
  - files:
      - logic/apbBridgePkg.sv
      - logic/apbReqIf.sv
      - logic/slotDecoder.sv
      - logic/indirectAddrReg.sv
      - logic/responseMux.sv
      - logic/apbSlotBridge.sv
  - target: simulation
    files:
      - verification/bridgeChecker.sv
      - verification/tbApbSlotBridge.sv

// File: verification/tbApbSlotBridge.sv
// ---------------------------------------------------------------------------
// Testbench for the APB slot bridge
// Clock, reset, random APB transfers and slave responses, watchdog
// ---------------------------------------------------------------------------

`timescale 1ns/100ps

module tbApbSlotBridge;

  localparam apbBridgePkg::slotVecT slotEnable = 16'hFDDF;
  localparam int clkPeriod = 40;
  localparam int resetCycles = 5;
  localparam int numTransfers = 200;
  localparam int maxWait = 8;
  localparam int timeoutNs = numTransfers * 2 * maxWait * clkPeriod + resetCycles * clkPeriod;

  logic PCLK = 1'b0;
  logic rstN;
  apbBridgePkg::mAddrT pAddr;
  logic pSel;
  logic pEnable;
  logic pWrite;
  logic [apbBridgePkg::dataW-1:0] pWData;
  logic [apbBridgePkg::dataW-1:0] pRData;
  logic pReady;
  logic pSlvErr;
  logic [apbBridgePkg::dataW-1:0] pAddrS;
  apbBridgePkg::slotVecT pSelS;
  logic pEnableS;
  logic pWriteS;
  logic [apbBridgePkg::dataW-1:0] pWDataS;
  apbBridgePkg::slotDataT pRDataS;
  apbBridgePkg::slotVecT pReadyS;
  apbBridgePkg::slotVecT pSlvErrS;
  int errorCount;
  int checkCount;
  logic [31:0] lfsrState = 32'd4;

  always #(clkPeriod / 2) PCLK = ~PCLK;

  apbSlotBridge #(.SlotEnable(slotEnable), .IndirectSlot(4'd15)) i_apbSlotBridge
  (
    .PCLK(PCLK), .rstN(rstN), .pAddr(pAddr), .pSel(pSel), .pEnable(pEnable),
    .pWrite(pWrite), .pWData(pWData), .pRData(pRData), .pReady(pReady),
    .pSlvErr(pSlvErr), .pAddrS(pAddrS), .pSelS(pSelS), .pEnableS(pEnableS),
    .pWriteS(pWriteS), .pWDataS(pWDataS), .pRDataS(pRDataS), .pReadyS(pReadyS),
    .pSlvErrS(pSlvErrS)
  );

  bridgeChecker #(.SlotEnable(slotEnable), .IndirectSlot(4'd15)) i_bridgeChecker
  (
    .PCLK(PCLK), .rstN(rstN), .pAddr(pAddr), .pSel(pSel), .pEnable(pEnable),
    .pWrite(pWrite), .pWData(pWData), .pRData(pRData), .pReady(pReady),
    .pSlvErr(pSlvErr), .pAddrS(pAddrS), .pSelS(pSelS), .pEnableS(pEnableS),
    .pWriteS(pWriteS), .pWDataS(pWDataS), .pRDataS(pRDataS), .pReadyS(pReadyS),
    .pSlvErrS(pSlvErrS), .errorCount(errorCount), .checkCount(checkCount)
  );

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  // One step per bit
  function automatic logic [31:0] randomBits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
      value = {value[30:0], lfsrState[0]};
    end
    return value;
  endfunction

  task automatic driveResponses(input logic forceReady);
    apbBridgePkg::slotDataT data;
    apbBridgePkg::slotVecT ready;
    for (int i = 0; i < apbBridgePkg::numSlots; i++)
    begin
      data[i] = randomBits(32);
    end
    // Mostly ready and forced high once the wait limit is near
    ready = apbBridgePkg::slotVecT'(randomBits(16) | randomBits(16));
    if (forceReady)
    begin
      ready = '1;
    end
    pRDataS <= data;
    pReadyS <= ready;
    pSlvErrS <= apbBridgePkg::slotVecT'(randomBits(16));
  endtask

  task automatic runTransfer(input logic [3:0] slot, input logic [11:0] offset,
                             input logic write, input logic [31:0] data);
    int waitCnt;
    logic done;
    @(posedge PCLK);
    pAddr <= {slot, offset};
    pSel <= 1'b1;
    pEnable <= 1'b0;
    pWrite <= write;
    pWData <= data;
    driveResponses(1'b0);
    @(posedge PCLK);
    pEnable <= 1'b1;
    driveResponses(1'b0);
    waitCnt = 0;
    done = 1'b0;
    while (!done)
    begin
      @(negedge PCLK);
      if (pReady)
      begin
        done = 1'b1;
      end
      else
      begin
        waitCnt++;
        @(posedge PCLK);
        driveResponses(waitCnt >= maxWait - 1);
      end
    end
  endtask

  task automatic idleCycle();
    @(posedge PCLK);
    pAddr <= 16'(randomBits(16));
    pSel <= 1'b0;
    pEnable <= 1'b0;
    driveResponses(1'b0);
  endtask

  initial
  begin
    logic [3:0] slot;
    rstN = 1'b0;
    pAddr = '0;
    pSel = 1'b0;
    pEnable = 1'b0;
    pWrite = 1'b0;
    pWData = '0;
    pRDataS = '0;
    pReadyS = '1;
    pSlvErrS = '0;
    repeat (resetCycles) @(posedge PCLK);
    rstN <= 1'b1;
    // Register slot must read zero straight after reset
    runTransfer(4'd15, 12'h000, 1'b0, 32'h0);
    for (int i = 1; i < numTransfers; i++)
    begin
      if (randomBits(2) == 0)
      begin
        idleCycle();
      end
      slot = (randomBits(2) == 0) ? 4'd15 : 4'(randomBits(4));
      runTransfer(slot, 12'(randomBits(12)), 1'(randomBits(1)), randomBits(32));
    end
    idleCycle();
    repeat (2) @(posedge PCLK);
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
    begin
      $display("Done: no errors");
    end
    else
    begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog
  initial
  begin
    #(timeoutNs);
    $display("Timeout: the transfers did not complete in the expected time");
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: verification/bridgeChecker.sv
// ---------------------------------------------------------------------------
// Checker for the APB slot bridge
// Reference model of all outputs, indirect register copy, error counting
// ---------------------------------------------------------------------------

`timescale 1ns/100ps

module bridgeChecker
#(
  parameter apbBridgePkg::slotVecT SlotEnable = '1,
  parameter logic [apbBridgePkg::slotIdxW-1:0] IndirectSlot = 4'd15
)
(
  input logic PCLK,
  input logic rstN,
  input logic [apbBridgePkg::mAddrW-1:0] pAddr,
  input logic pSel,
  input logic pEnable,
  input logic pWrite,
  input logic [apbBridgePkg::dataW-1:0] pWData,
  input logic [apbBridgePkg::dataW-1:0] pRData,
  input logic pReady,
  input logic pSlvErr,
  input logic [apbBridgePkg::dataW-1:0] pAddrS,
  input apbBridgePkg::slotVecT pSelS,
  input logic pEnableS,
  input logic pWriteS,
  input logic [apbBridgePkg::dataW-1:0] pWDataS,
  input apbBridgePkg::slotDataT pRDataS,
  input apbBridgePkg::slotVecT pReadyS,
  input apbBridgePkg::slotVecT pSlvErrS,
  output int errorCount,
  output int checkCount
);

  localparam int offW = apbBridgePkg::offsetW;
  localparam int dW = apbBridgePkg::dataW;

  logic [dW-1:0] regCopy = '0;
  apbBridgePkg::slotVecT expSelS;
  logic [dW-1:0] expRData;
  logic expReady;
  logic expErr;
  logic [dW-1:0] expAddrS;

  initial
  begin
    errorCount = 0;
    checkCount = 0;
  end

  // Expected outputs from the decode and response rules
  function automatic void refOutputs(
    input logic [apbBridgePkg::mAddrW-1:0] addr,
    input logic sel,
    input logic [dW-1:0] regVal,
    input apbBridgePkg::slotDataT rdS,
    input apbBridgePkg::slotVecT rdyS,
    input apbBridgePkg::slotVecT errS,
    output apbBridgePkg::slotVecT selS,
    output logic [dW-1:0] rData,
    output logic ready,
    output logic err,
    output logic [dW-1:0] addrS
  );
    logic [apbBridgePkg::slotIdxW-1:0] slot;
    logic hit;
    slot = addr[apbBridgePkg::mAddrW-1:offW];
    // Register slot is reachable whatever its mask bit says
    hit = sel && (SlotEnable[slot] || slot == IndirectSlot);
    selS = '0;
    if (hit && slot != IndirectSlot)
    begin
      selS[slot] = 1'b1;
    end
    if (!hit)
    begin
      rData = '0;
      ready = 1'b1;
      err = 1'b0;
    end
    else if (slot == IndirectSlot)
    begin
      rData = regVal;
      ready = 1'b1;
      err = 1'b0;
    end
    else
    begin
      rData = rdS[slot];
      ready = rdyS[slot];
      err = errS[slot];
    end
    addrS = {regVal[dW-1:offW], addr[offW-1:0]};
  endfunction

  task automatic compareValue(input string name, input logic [dW-1:0] expected,
                              input logic [dW-1:0] actual);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // Outputs are settled half a cycle after the inputs change
  always @(negedge PCLK)
  begin
    if (rstN)
    begin
      refOutputs(pAddr, pSel, regCopy, pRDataS, pReadyS, pSlvErrS,
                 expSelS, expRData, expReady, expErr, expAddrS);
      compareValue("pSelS", dW'(expSelS), dW'(pSelS));
      compareValue("pRData", expRData, pRData);
      compareValue("pReady", dW'(expReady), dW'(pReady));
      compareValue("pSlvErr", dW'(expErr), dW'(pSlvErr));
      compareValue("pAddrS", expAddrS, pAddrS);
      compareValue("pEnableS", dW'(pEnable), dW'(pEnableS));
      compareValue("pWriteS", dW'(pWrite), dW'(pWriteS));
      compareValue("pWDataS", pWData, pWDataS);
    end
    // Value the register takes at the coming rising edge
    if (!rstN)
    begin
      regCopy = '0;
    end
    else if (pSel && pEnable && pWrite && pAddr[apbBridgePkg::mAddrW-1:offW] == IndirectSlot)
    begin
      regCopy = pWData;
    end
  end

endmodule

// File: logic/apbSlotBridge.sv
// ---------------------------------------------------------------------------
// APB3 slot bridge top level
// One master fanned out to sixteen slots, one slot holds the indirect register
// ---------------------------------------------------------------------------

`timescale 1ns/100ps

module apbSlotBridge
#(
  parameter apbBridgePkg::slotVecT SlotEnable = '1,
  parameter logic [apbBridgePkg::slotIdxW-1:0] IndirectSlot = 4'd15
)
(
  input logic PCLK,
  input logic rstN,

  // Master side
  input apbBridgePkg::mAddrT pAddr,
  input logic pSel,
  input logic pEnable,
  input logic pWrite,
  input logic [apbBridgePkg::dataW-1:0] pWData,
  output logic [apbBridgePkg::dataW-1:0] pRData,
  output logic pReady,
  output logic pSlvErr,

  // Slave side
  output logic [apbBridgePkg::dataW-1:0] pAddrS,
  output apbBridgePkg::slotVecT pSelS,
  output logic pEnableS,
  output logic pWriteS,
  output logic [apbBridgePkg::dataW-1:0] pWDataS,
  input apbBridgePkg::slotDataT pRDataS,
  input apbBridgePkg::slotVecT pReadyS,
  input apbBridgePkg::slotVecT pSlvErrS
);

  logic [apbBridgePkg::dataW-1:0] regData;

  apbReqIf req();

  slotDecoder
  #(
    .SlotEnable(SlotEnable),
    .IndirectSlot(IndirectSlot)
  )
  i_slotDecoder
  (
    .pAddr(pAddr),
    .pSel(pSel),
    .pEnable(pEnable),
    .pWrite(pWrite),
    .pWData(pWData),
    .req(req.dec),
    .pSelS(pSelS)
  );

  indirectAddrReg
  #(
    .IndirectSlot(IndirectSlot)
  )
  i_indirectAddrReg
  (
    .PCLK(PCLK),
    .rstN(rstN),
    .req(req.regs),
    .regData(regData)
  );

  responseMux
  #(
    .IndirectSlot(IndirectSlot)
  )
  i_responseMux
  (
    .req(req.mux),
    .regData(regData),
    .pRDataS(pRDataS),
    .pReadyS(pReadyS),
    .pSlvErrS(pSlvErrS),
    .pRData(pRData),
    .pReady(pReady),
    .pSlvErr(pSlvErr)
  );

  // Register supplies the upper 20 bits, master supplies the offset
  assign pAddrS = {regData[apbBridgePkg::dataW-1:apbBridgePkg::offsetW],
                   pAddr.raw[apbBridgePkg::offsetW-1:0]};

  assign pEnableS = pEnable;
  assign pWriteS = pWrite;
  assign pWDataS = pWData;

endmodule

// File: logic/responseMux.sv
// ---------------------------------------------------------------------------
// Response multiplexer
// Read data, ready and error of the addressed slot back to the master
// ---------------------------------------------------------------------------

`timescale 1ns/100ps

module responseMux
#(
  parameter logic [apbBridgePkg::slotIdxW-1:0] IndirectSlot = 4'd15
)
(
  apbReqIf.mux req,
  input logic [apbBridgePkg::dataW-1:0] regData,
  input apbBridgePkg::slotDataT pRDataS,
  input apbBridgePkg::slotVecT pReadyS,
  input apbBridgePkg::slotVecT pSlvErrS,
  output logic [apbBridgePkg::dataW-1:0] pRData,
  output logic pReady,
  output logic pSlvErr
);

  apbBridgePkg::slotDataT dataV;
  apbBridgePkg::slotVecT readyV;
  apbBridgePkg::slotVecT errV;

  // Register slot replaces its external response
  always_comb
  begin
    dataV = pRDataS;
    readyV = pReadyS;
    errV = pSlvErrS;
    dataV[IndirectSlot] = regData;
    readyV[IndirectSlot] = 1'b1;
    errV[IndirectSlot] = 1'b0;
  end

  // AND-OR select, the select is one-hot or zero
  always_comb
  begin
    pRData = '0;
    for (int i = 0; i < apbBridgePkg::numSlots; i++)
    begin
      if (req.slotSel[i])
      begin
        pRData = pRData | dataV[i];
      end
    end
  end

  // Nothing addressed answers ready with no error
  always_comb
  begin
    if (req.anySel)
    begin
      pReady = |(req.slotSel & readyV);
      pSlvErr = |(req.slotSel & errV);
    end
    else
    begin
      pReady = 1'b1;
      pSlvErr = 1'b0;
    end
  end

endmodule

// File: logic/indirectAddrReg.sv
// ---------------------------------------------------------------------------
// Indirect address register
// Upper bits feed the slave address, written and read through its own slot
// ---------------------------------------------------------------------------

`timescale 1ns/100ps

module indirectAddrReg
#(
  parameter logic [apbBridgePkg::slotIdxW-1:0] IndirectSlot = 4'd15
)
(
  input logic PCLK,
  input logic rstN,
  apbReqIf.regs req,
  output logic [apbBridgePkg::dataW-1:0] regData
);

  logic wrEn;

  // Write access to the register slot
  assign wrEn = req.access & req.write & req.slotSel[IndirectSlot];

  always_ff @(posedge PCLK)
  begin
    if (!rstN)
    begin
      regData <= '0;
    end
    else if (wrEn)
    begin
      regData <= req.wData;
    end
  end

endmodule

// File: logic/slotDecoder.sv
// ---------------------------------------------------------------------------
// Slot decoder
// Upper address nibble to one-hot slot select, gated by pSel and the mask
// ---------------------------------------------------------------------------

`timescale 1ns/100ps

module slotDecoder
#(
  parameter apbBridgePkg::slotVecT SlotEnable = '1,
  parameter logic [apbBridgePkg::slotIdxW-1:0] IndirectSlot = 4'd15
)
(
  input apbBridgePkg::mAddrT pAddr,
  input logic pSel,
  input logic pEnable,
  input logic pWrite,
  input logic [apbBridgePkg::dataW-1:0] pWData,
  apbReqIf.dec req,
  output apbBridgePkg::slotVecT pSelS
);

  // Bit of the register slot
  localparam apbBridgePkg::slotVecT regMask = apbBridgePkg::slotVecT'(1) << IndirectSlot;

  // The register slot answers even when its mask bit is clear
  localparam apbBridgePkg::slotVecT enMask = SlotEnable | regMask;

  apbBridgePkg::slotVecT oneHot;
  apbBridgePkg::slotVecT sel;

  // Nibble decode
  always_comb
  begin
    oneHot = '0;
    oneHot[pAddr.field.slot] = 1'b1;
  end

  always_comb
  begin
    if (pSel)
    begin
      sel = oneHot & enMask;
    end
    else
    begin
      sel = '0;
    end
  end

  assign req.slotSel = sel;
  assign req.anySel = |sel;
  assign req.access = pSel & pEnable;
  assign req.write = pWrite;
  assign req.wData = pWData;

  // No external slave sits behind the register slot
  assign pSelS = sel & ~regMask;

endmodule

// File: logic/apbReqIf.sv
// ---------------------------------------------------------------------------
// Decoded APB request shared by decoder, indirect register and response mux
// ---------------------------------------------------------------------------

`timescale 1ns/100ps

interface apbReqIf;

  // One-hot slot select, indirect slot included
  apbBridgePkg::slotVecT slotSel;

  // Access phase of the transfer
  logic access;
  logic write;
  logic [apbBridgePkg::dataW-1:0] wData;

  // Some enabled slot is addressed
  logic anySel;

  modport dec
  (
    output slotSel,
    output access,
    output write,
    output wData,
    output anySel
  );

  // Indirect register side
  modport regs
  (
    input slotSel,
    input access,
    input write,
    input wData
  );

  modport mux
  (
    input slotSel,
    input anySel
  );

endinterface

// File: logic/apbBridgePkg.sv
// ---------------------------------------------------------------------------
// Shared constants and types of the APB slot bridge
// Slot count, address and data widths, master address union, slot vectors
// ---------------------------------------------------------------------------

package apbBridgePkg;

  // Sixteen slots selected by the upper nibble
  localparam int unsigned numSlots = 16;
  localparam int unsigned slotIdxW = $clog2(numSlots);

  // Master address splits into slot index and in-slot offset
  localparam int unsigned mAddrW = 16;
  localparam int unsigned offsetW = mAddrW - slotIdxW;

  // APB data and full slave address width
  localparam int unsigned dataW = 32;

  // Master address, seen as one word or as slot plus offset
  typedef union packed
  {
    logic [mAddrW-1:0] raw;
    struct packed
    {
      logic [slotIdxW-1:0] slot;
      logic [offsetW-1:0] offset;
    } field;
  } mAddrT;

  // One bit per slot
  typedef logic [numSlots-1:0] slotVecT;

  // One read data word per slot
  typedef logic [numSlots-1:0][dataW-1:0] slotDataT;

endpackage
